// ==== verilog/sram_defines.svh ====
// Geometry of the tiled SRAM and of its block-RAM tiles
// Depth and widths shared by the packages, the RTL and the testbench

`ifndef SRAM_DEFINES_SVH
`define SRAM_DEFINES_SVH

// Whole memory
`define SRAM_NUM_WORDS   2048
`define SRAM_DATA_WIDTH  160
`define SRAM_BYTE_WIDTH  8
`define SRAM_ADDR_WIDTH  11 // log2 of SRAM_NUM_WORDS
`define SRAM_BE_WIDTH    20 // One enable per data byte

// Single tile
`define TILE_WIDTH       64
`define TILE_DEPTH       512
`define TILE_ADDR_WIDTH  9

// Tile array
`define SRAM_NUM_COLUMNS 3 // Two full columns plus one 32-bit column
`define SRAM_NUM_ROWS    4
`define ROW_SEL_WIDTH    2

`endif

// ==== verilog/sram_geom_pkg.sv ====
// Geometry types for the tiled SRAM
// Address, data and byte-enable types of the memory and of one tile

`include "sram_defines.svh"

package sram_geom_pkg;

  // Word address of the whole memory
  typedef logic [`SRAM_ADDR_WIDTH-1:0] addrT;

  // Full data word and its byte enables
  typedef logic [`SRAM_DATA_WIDTH-1:0] dataT;
  typedef logic [`SRAM_BE_WIDTH-1:0]   beT;

  // One tile word, with one write enable per byte
  typedef logic [`TILE_WIDTH-1:0]                    tileDataT;
  typedef logic [`TILE_WIDTH/`SRAM_BYTE_WIDTH-1:0]   tileBeT;

  // Address inside a tile, taken from the low address bits
  typedef logic [`TILE_ADDR_WIDTH-1:0] tileAddrT;

  // Tile row, taken from the high address bits
  typedef logic [`ROW_SEL_WIDTH-1:0] rowSelT;

endpackage

// ==== verilog/sram_op_pkg.sv ====
// Request opcodes of the tiled SRAM

package sram_op_pkg;

  // One request is either a read or a byte-masked write
  typedef enum logic {
    OpRead  = 1'b0,
    OpWrite = 1'b1
  } sramOpE;

endpackage

// ==== verilog/bram_tile.sv ====
// Behavioral block-RAM tile of 512 words by 64 bits
// Byte-masked writes and a registered read port with one cycle of latency

`timescale 1ns/10ps
`include "sram_defines.svh"

module bram_tile (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   en_i,
  input  sram_geom_pkg::tileBeT  we_i,    // One write enable per byte
  input  sram_geom_pkg::tileAddrT addr_i,
  input  sram_geom_pkg::tileDataT wdata_i,
  output sram_geom_pkg::tileDataT rdata_o
);
  import sram_geom_pkg::*;

  localparam int NumBytes = `TILE_WIDTH / `SRAM_BYTE_WIDTH;

  tileDataT mem [`TILE_DEPTH];
  tileDataT rdataQ;

  // Contents start at zero
  initial begin
    for (int i = 0; i < `TILE_DEPTH; i++) begin
      mem[i] = '0;
    end
  end

  // Write only the enabled bytes
  always @(posedge clk_i) begin
    if (en_i) begin
      for (int b = 0; b < NumBytes; b++) begin
        if (we_i[b]) begin
          mem[addr_i][b*`SRAM_BYTE_WIDTH +: `SRAM_BYTE_WIDTH] <=
            wdata_i[b*`SRAM_BYTE_WIDTH +: `SRAM_BYTE_WIDTH];
        end
      end
    end
  end

  // Output register holds its value between reads
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdataQ <= '0;
    end else if (en_i && (we_i == '0)) begin // Enabled with no byte enables is a read
      rdataQ <= mem[addr_i];
    end
  end

  assign rdata_o = rdataQ;

endmodule

// ==== verilog/bram_column.sv ====
// One column of the tile array, four tiles stacked over the address range
// Decodes the row for writes, registers the row on reads and muxes the
// tile outputs down to the column width

`timescale 1ns/10ps
`include "sram_defines.svh"

module bram_column #(
  parameter int ColumnWidth = 64 // 64 for full columns, 32 for the last one
) (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        rdEn_i,
  input  logic                        wrEn_i,
  input  sram_geom_pkg::rowSelT       rowSel_i,
  input  sram_geom_pkg::tileAddrT     tileAddr_i,
  input  logic [ColumnWidth-1:0]      wdata_i,
  input  logic [ColumnWidth/8-1:0]    be_i,
  output logic [ColumnWidth-1:0]      rdata_o
);
  import sram_geom_pkg::*;

  localparam int ColumnBytes = ColumnWidth / `SRAM_BYTE_WIDTH;

  tileDataT wdataExt;
  tileBeT   beExt;
  logic     accessEn;
  rowSelT   rowSelQ;

  logic     [`SRAM_NUM_ROWS-1:0] tileEn;
  tileDataT                      tileRdata [`SRAM_NUM_ROWS];

  // Widen data and byte enables to the tile width
  always_comb begin
    wdataExt                  = '0;
    wdataExt[ColumnWidth-1:0] = wdata_i;
  end

  always_comb begin
    beExt = '0;
    if (wrEn_i) begin // Reads never write
      beExt[ColumnBytes-1:0] = be_i;
    end
  end

  // A write that enables no byte of this column leaves its tiles idle,
  // otherwise the tile would treat it as a read and disturb its output
  assign accessEn = rdEn_i | (wrEn_i & (|be_i));

  // Only the addressed row is enabled
  always_comb begin
    for (int r = 0; r < `SRAM_NUM_ROWS; r++) begin
      tileEn[r] = accessEn && (rowSel_i == rowSelT'(r));
    end
  end

  for (genvar r = 0; r < `SRAM_NUM_ROWS; r++) begin : gen_tile
    bram_tile tile_i (
      .clk_i   ( clk_i        ),
      .rst_ni  ( rst_ni       ),
      .en_i    ( tileEn[r]    ),
      .we_i    ( beExt        ),
      .addr_i  ( tileAddr_i   ),
      .wdata_i ( wdataExt     ),
      .rdata_o ( tileRdata[r] )
    );
  end

  // Row of the read in flight, steers the output mux one cycle later
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rowSelQ <= '0;
    end else if (rdEn_i) begin
      rowSelQ <= rowSel_i;
    end
  end

  assign rdata_o = tileRdata[rowSelQ][ColumnWidth-1:0]; // Drop the zero-extended upper bits

endmodule

// ==== verilog/tiled_sram.sv ====
// Single-port SRAM of 2048 words by 160 bits with byte enables
// Built from columns of 64-bit block-RAM tiles, one cycle read latency

`timescale 1ns/10ps
`include "sram_defines.svh"

module tiled_sram (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  req_i,   // Taken on every edge where high
  input  sram_op_pkg::sramOpE   op_i,
  input  sram_geom_pkg::addrT   addr_i,
  input  sram_geom_pkg::dataT   wdata_i,
  input  sram_geom_pkg::beT     be_i,
  output sram_geom_pkg::dataT   rdata_o,
  output logic                  rvalid_o // High in the cycle the read data arrives
);
  import sram_geom_pkg::*;
  import sram_op_pkg::*;

  // Width of the narrow last column
  localparam int LastWidth = `SRAM_DATA_WIDTH - (`SRAM_NUM_COLUMNS - 1) * `TILE_WIDTH;
  localparam int TileBytes = `TILE_WIDTH / `SRAM_BYTE_WIDTH;

  logic     rdEn;
  logic     wrEn;
  rowSelT   rowSel;
  tileAddrT tileAddr;
  logic     rvalidQ;

  // Request decode
  assign rdEn = req_i && (op_i == OpRead);
  assign wrEn = req_i && (op_i == OpWrite);

  // Upper bits pick the row, lower bits address inside the tile
  assign rowSel   = addr_i[`SRAM_ADDR_WIDTH-1 -: `ROW_SEL_WIDTH];
  assign tileAddr = addr_i[`TILE_ADDR_WIDTH-1:0];

  for (genvar c = 0; c < `SRAM_NUM_COLUMNS; c++) begin : gen_column
    localparam int ColW = (c == `SRAM_NUM_COLUMNS - 1) ? LastWidth : `TILE_WIDTH;

    bram_column #(
      .ColumnWidth ( ColW )
    ) column_i (
      .clk_i      ( clk_i                                          ),
      .rst_ni     ( rst_ni                                         ),
      .rdEn_i     ( rdEn                                           ),
      .wrEn_i     ( wrEn                                           ),
      .rowSel_i   ( rowSel                                         ),
      .tileAddr_i ( tileAddr                                       ),
      .wdata_i    ( wdata_i[c*`TILE_WIDTH +: ColW]                 ),
      .be_i       ( be_i[c*TileBytes +: ColW/`SRAM_BYTE_WIDTH]     ),
      .rdata_o    ( rdata_o[c*`TILE_WIDTH +: ColW]                 )
    );
  end

  // Read valid follows the read by one cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalidQ <= 1'b0;
    end else begin
      rvalidQ <= rdEn;
    end
  end

  assign rvalid_o = rvalidQ;

endmodule

// ==== verification/tiled_sram_tb.sv ====
// Testbench for the tiled SRAM
// Replays request vectors from a file, checks read data and read valid
// cycle by cycle and reports per test

`timescale 1ns/10ps

module tiled_sram_tb;
  import sram_geom_pkg::*;
  import sram_op_pkg::*;

  localparam int ClkPeriod   = 40;
  localparam int ResetCycles = 8;
  localparam int SlackCycles = 20; // Margin on top of vectors and reset

  logic   clk_i;
  logic   rst_ni;
  logic   req_i;
  sramOpE op_i;
  addrT   addr_i;
  dataT   wdata_i;
  beT     be_i;
  dataT   rdata_o;
  logic   rvalid_o;

  // Vectors as loaded from the file
  logic   vecReq [$];
  sramOpE vecOp [$];
  addrT   vecAddr [$];
  beT     vecBe [$];
  dataT   vecWdata [$];
  dataT   vecExpect [$];
  int     vecTest [$];

  int     numVectors;
  bit     loaded;
  int     passCount;
  int     failCount;
  int     testChecks;
  int     testErrors;
  int     testsPassed;
  int     testsFailed;
  dataT   lastRead;    // Value rdata_o must hold between reads

  tiled_sram tiled_sram_i (
    .clk_i    ( clk_i    ),
    .rst_ni   ( rst_ni   ),
    .req_i    ( req_i    ),
    .op_i     ( op_i     ),
    .addr_i   ( addr_i   ),
    .wdata_i  ( wdata_i  ),
    .be_i     ( be_i     ),
    .rdata_o  ( rdata_o  ),
    .rvalid_o ( rvalid_o )
  );

  always #(ClkPeriod / 2) clk_i = ~clk_i;

  task automatic checkData(input string name, input dataT expected, input dataT actual);
    testChecks++;
    if (actual !== expected) begin
      $display("FAILED at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
      failCount++;
      testErrors++;
    end else begin
      passCount++;
    end
  endtask

  task automatic checkValid(input string name, input logic expected, input logic actual);
    testChecks++;
    if (actual !== expected) begin
      $display("FAILED at %0t ns: %s expected %b, got %b", $time, name, expected, actual);
      failCount++;
      testErrors++;
    end else begin
      passCount++;
    end
  endtask

  function automatic string testName(input int t);
    case (t)
      1:       return "reset and initial contents";
      2:       return "row selection";
      3:       return "byte-enable merge";
      4:       return "pipelined reads";
      5:       return "hold behavior";
      default: return "unnamed";
    endcase
  endfunction

  // Lines starting with # are comments
  task automatic loadVectors(output bit ok);
    int    fd;
    int    fields;
    string line;
    int    reqVal;
    int    opVal;
    int    testVal;
    addrT  addrVal;
    beT    beVal;
    dataT  wdataVal;
    dataT  expVal;
    ok = 1'b0;
    fd = $fopen("verification/sram_vectors.txt", "r");
    if (fd == 0) begin
      $display("The vectors file verification/sram_vectors.txt could not be opened");
    end else begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() == 0 || line[0] == "#") begin
          continue;
        end
        fields = $sscanf(line, "%d %d %h %h %h %h %d",
                         reqVal, opVal, addrVal, beVal, wdataVal, expVal, testVal);
        if (fields <= 0) begin
          continue; // Blank line
        end
        if (fields != 7) begin
          $display("A line of the vectors file has %0d fields instead of 7: %s", fields, line);
          failCount++;
          continue;
        end
        vecReq.push_back(reqVal != 0);
        vecOp.push_back(sramOpE'(opVal));
        vecAddr.push_back(addrVal);
        vecBe.push_back(beVal);
        vecWdata.push_back(wdataVal);
        vecExpect.push_back(expVal);
        vecTest.push_back(testVal);
      end
      $fclose(fd);
      ok = (vecReq.size() > 0);
    end
  endtask

  task automatic driveVector(input int idx);
    req_i   = vecReq[idx];
    op_i    = vecOp[idx];
    addr_i  = vecAddr[idx];
    be_i    = vecBe[idx];
    wdata_i = vecWdata[idx];
  endtask

  task automatic driveIdle();
    req_i   = 1'b0;
    op_i    = OpRead;
    addr_i  = '0;
    be_i    = '0;
    wdata_i = '0;
  endtask

  task automatic finishTest(input int t);
    if (testErrors == 0) begin
      testsPassed++;
      $display("Test %0d (%s) passed, %0d checks", t, testName(t), testChecks);
    end else begin
      testsFailed++;
      $display("Test %0d (%s) had %0d errors in %0d checks", t, testName(t), testErrors,
               testChecks);
    end
    testChecks = 0;
    testErrors = 0;
  endtask

  // Response to the request taken at the last rising edge
  task automatic compareResponse(input int idx);
    if (vecReq[idx] && (vecOp[idx] == OpRead)) begin
      checkValid("rvalid_o", 1'b1, rvalid_o);
      checkData("rdata_o", vecExpect[idx], rdata_o);
      lastRead = vecExpect[idx];
    end else begin
      checkValid("rvalid_o", 1'b0, rvalid_o);
      checkData("rdata_o", lastRead, rdata_o);
    end
    if ((idx == numVectors - 1) || (vecTest[idx + 1] != vecTest[idx])) begin
      finishTest(vecTest[idx]);
    end
  endtask

  task automatic applyReset();
    rst_ni = 1'b0;
    repeat (ResetCycles) @(negedge clk_i);
    rst_ni = 1'b1;
    checkValid("rvalid_o", 1'b0, rvalid_o); // Counts toward the first test
    checkData("rdata_o", '0, rdata_o);
    lastRead = '0;
  endtask

  // Inputs change on the falling edge, outputs are sampled there too
  task automatic runVectors();
    for (int i = 0; i <= numVectors; i++) begin
      @(negedge clk_i);
      if (i > 0) begin
        compareResponse(i - 1);
      end
      if (i < numVectors) begin
        driveVector(i);
      end else begin
        driveIdle();
      end
    end
  endtask

  initial begin
    bit ok;
    clk_i       = 1'b0;
    rst_ni      = 1'b0;
    loaded      = 1'b0;
    passCount   = 0;
    failCount   = 0;
    testChecks  = 0;
    testErrors  = 0;
    testsPassed = 0;
    testsFailed = 0;
    driveIdle();
    loadVectors(ok);
    if (ok) begin
      numVectors = vecReq.size();
      loaded     = 1'b1;
      applyReset();
      runVectors();
    end else begin
      $display("No usable request was found in the vectors file, nothing was tested");
      failCount++;
    end
    $display("Tests passed %0d, failed %0d; checks passed %0d, failed %0d",
             testsPassed, testsFailed, passCount, failCount);
    if (failCount == 0 && testsFailed == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // Watchdog sized from the vector count
  initial begin
    wait (loaded);
    #((numVectors + ResetCycles + SlackCycles) * ClkPeriod);
    $display("The run did not finish within %0d cycles and was stopped",
             numVectors + ResetCycles + SlackCycles);
    $display("Test failed");
    $finish;
  end

endmodule

// ==== build.f ====
+incdir+verilog
verilog/sram_geom_pkg.sv
verilog/sram_op_pkg.sv
verilog/bram_tile.sv
verilog/bram_column.sv
verilog/tiled_sram.sv
verification/tiled_sram_tb.sv

// ==== verification/sram_vectors.txt ====
# Columns: req op addr be wdata expected_rdata test
# req 1 issues a request, 0 is an idle cycle; op 0 is a read, 1 a write
# addr, be, wdata and expected_rdata are hex; expected_rdata is used on reads only
# Test 1, unwritten words in all four rows read as zero
1 0 005 00000 0 0 1
1 0 234 00000 0 0 1
0 0 000 00000 0 0 1
1 0 4a1 00000 0 0 1
1 0 7ff 00000 0 0 1
# Test 2, full-word writes at the same tile address in every row
1 1 010 fffff c0ffee010123456789abcdeffedcba9876543210 0 2
1 1 210 fffff a5a5a5a55a5a5a5a5a5a5a5a3c3c3c3c3c3c3c3c 0 2
1 1 410 fffff deadbeef00112233445566778899aabbccddeeff 0 2
1 1 610 fffff 876543211357924680aceb9df0e1d2c3b4a59687 0 2
0 0 000 00000 0 0 2
1 0 010 00000 0 c0ffee010123456789abcdeffedcba9876543210 2
1 0 210 00000 0 a5a5a5a55a5a5a5a5a5a5a5a3c3c3c3c3c3c3c3c 2
1 0 410 00000 0 deadbeef00112233445566778899aabbccddeeff 2
1 0 610 00000 0 876543211357924680aceb9df0e1d2c3b4a59687 2
# Test 3, partial writes merge byte by byte, narrow column included
1 1 3a7 fffff 1111111111111111111111111111111111111111 0 3
1 1 3a7 0000f 2222222222222222222222222222222222222222 0 3
1 1 3a7 f0010 3333333333333333333333333333333333333333 0 3
1 1 3a7 0a100 4444444444444444444444444444444444444444 0 3
1 1 3a7 00003 5555555555555555555555555555555555555555 0 3
0 0 000 00000 0 0 3
1 0 3a7 00000 0 3333333344114411111111441111113322225555 3
# Test 4, back-to-back reads across rows
1 0 610 00000 0 876543211357924680aceb9df0e1d2c3b4a59687 4
1 0 010 00000 0 c0ffee010123456789abcdeffedcba9876543210 4
1 0 410 00000 0 deadbeef00112233445566778899aabbccddeeff 4
1 0 210 00000 0 a5a5a5a55a5a5a5a5a5a5a5a3c3c3c3c3c3c3c3c 4
1 0 3a7 00000 0 3333333344114411111111441111113322225555 4
# Test 5, read data holds through idle cycles and writes
1 0 410 00000 0 deadbeef00112233445566778899aabbccddeeff 5
0 0 000 00000 0 0 5
1 1 410 fffff 0badcafeffffffff00000000123456789abcdef0 0 5
0 0 000 00000 0 0 5
1 1 411 fffff 4444444444444444444444444444444444444444 0 5
0 0 000 00000 0 0 5
1 0 410 00000 0 0badcafeffffffff00000000123456789abcdef0 5
1 0 411 00000 0 4444444444444444444444444444444444444444 5
